/* logic/mc_bridge_pkg.sv */
`default_nettype none

package mc_bridge_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////
  localparam int proc_addr_width_c = 32;
  localparam int mc_data_width_c   = 32;
  localparam int mc_mask_width_c   = 4;
  localparam int mc_addr_width_c   = 28;
  localparam int mc_cord_width_c   = 6;
  localparam int tag_width_c       = 8;

  // wide enough to carry ids that are out of range
  localparam int reg_id_width_c    = 5;

  ////////////////////////////////////////
  // processor address fields
  ////////////////////////////////////////
  localparam int dram_bit_c           = 31;
  localparam int y_msb_c              = 29;
  localparam int y_lsb_c              = 24;
  localparam int x_msb_c              = 23;
  localparam int x_lsb_c              = 18;
  localparam int word_msb_c           = 17;
  localparam int word_lsb_c           = 2;
  localparam int byte_offset_width_c  = 2;

  ////////////////////////////////////////
  // dram bank hash
  ////////////////////////////////////////
  localparam int vcache_offset_width_c = 3;
  localparam int num_banks_c           = 8;
  localparam int bank_width_c          = 3;
  localparam int num_tiles_y_c         = 8;

  // hash input is address bits 30 down to 5
  localparam int hash_input_width_c =
    proc_addr_width_c - 1 - word_lsb_c - vcache_offset_width_c;
  localparam int hash_index_width_c = hash_input_width_c - bank_width_c;

  typedef enum logic [1:0]
  {
    size_1 = 2'd0,
    size_2 = 2'd1,
    size_4 = 2'd2
  } msg_size_e;

  typedef enum logic [1:0]
  {
    op_load         = 2'd0,
    op_store_word   = 2'd1,
    op_store_masked = 2'd2
  } mc_op_e;

  // index width that stays at least one bit for a single entry
  function automatic int safe_clog2_f(input int value);
    return (value > 1) ? $clog2(value) : 1;
  endfunction

endpackage

`default_nettype wire

/* logic/mc_bridge_if.sv */
`default_nettype none

// head of the command queue
interface mc_cmd_if
  import mc_bridge_pkg::*;
();

  logic                         v;
  logic                         yumi;
  logic                         write;
  msg_size_e                    size;
  logic [proc_addr_width_c-1:0] addr;
  logic [mc_data_width_c-1:0]   data;
  logic [tag_width_c-1:0]       tag;

  modport queue_mp
  (
    output v, write, size, addr, data, tag,
    input  yumi
  );

  modport former_mp
  (
    input  v, write, size, addr, data, tag,
    output yumi
  );

endinterface

// id allocation between packet former and reorder buffer
interface mc_alloc_if
  import mc_bridge_pkg::*;
#(
  parameter int id_width_p = 2
)
();

  logic                   alloc_v;
  logic [id_width_p-1:0]  alloc_id;
  logic                   alloc_yumi;
  logic [tag_width_c-1:0] tag;
  logic                   write;

  modport buffer_mp
  (
    output alloc_v, alloc_id,
    input  alloc_yumi, tag, write
  );

  modport former_mp
  (
    input  alloc_v, alloc_id,
    output alloc_yumi, tag, write
  );

endinterface

`default_nettype wire

/* logic/mc_cmd_queue.sv */
`default_nettype none

module mc_cmd_queue
  import mc_bridge_pkg::*;
#(
  parameter int queue_depth_p = 4
)
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         cmd_v_i,
  input  logic                         cmd_write_i,
  input  msg_size_e                    cmd_size_i,
  input  logic [proc_addr_width_c-1:0] cmd_addr_i,
  input  logic [mc_data_width_c-1:0]   cmd_data_i,
  input  logic [tag_width_c-1:0]       cmd_tag_i,
  output logic                         cmd_ready_o,
  mc_cmd_if.queue_mp                   head
);

  localparam int ptr_width_lp = safe_clog2_f(queue_depth_p);
  localparam int cnt_width_lp = safe_clog2_f(queue_depth_p + 1);

  logic                         write_mem [queue_depth_p];
  msg_size_e                    size_mem  [queue_depth_p];
  logic [proc_addr_width_c-1:0] addr_mem  [queue_depth_p];
  logic [mc_data_width_c-1:0]   data_mem  [queue_depth_p];
  logic [tag_width_c-1:0]       tag_mem   [queue_depth_p];

  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    push;
  logic                    pop;

  function automatic logic [ptr_width_lp-1:0] next_ptr_f(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(queue_depth_p - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign cmd_ready_o = (count_r != cnt_width_lp'(queue_depth_p));
  assign push        = cmd_v_i & cmd_ready_o;
  assign pop         = head.yumi;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= next_ptr_f(wr_ptr_r);
      if (pop)
        rd_ptr_r <= next_ptr_f(rd_ptr_r);
      count_r <= count_r + cnt_width_lp'(push) - cnt_width_lp'(pop);
    end
  end

  // command storage
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      write_mem[wr_ptr_r] <= cmd_write_i;
      size_mem[wr_ptr_r]  <= cmd_size_i;
      addr_mem[wr_ptr_r]  <= cmd_addr_i;
      data_mem[wr_ptr_r]  <= cmd_data_i;
      tag_mem[wr_ptr_r]   <= cmd_tag_i;
    end
  end

  // oldest entry at the head
  assign head.v     = (count_r != '0);
  assign head.write = write_mem[rd_ptr_r];
  assign head.size  = size_mem[rd_ptr_r];
  assign head.addr  = addr_mem[rd_ptr_r];
  assign head.data  = data_mem[rd_ptr_r];
  assign head.tag   = tag_mem[rd_ptr_r];

endmodule

`default_nettype wire

/* logic/mc_packet_former.sv */
`default_nettype none

module mc_packet_former
  import mc_bridge_pkg::*;
#(
  parameter int max_outstanding_p = 4
)
(
  input  logic                           pkt_ready_i,
  mc_cmd_if.former_mp                    cmd,
  mc_alloc_if.former_mp                  alloc,
  output logic                           pkt_v_o,
  output logic                           pkt_is_byte_o,
  output logic                           pkt_is_hex_o,
  output mc_op_e                         pkt_op_o,
  output logic [mc_addr_width_c-1:0]     pkt_addr_o,
  output logic [mc_cord_width_c-1:0]     pkt_x_o,
  output logic [mc_cord_width_c-1:0]     pkt_y_o,
  output logic [reg_id_width_c-1:0]      pkt_reg_id_o,
  output logic [mc_data_width_c-1:0]     pkt_payload_o,
  output logic [mc_mask_width_c-1:0]     pkt_mask_o,
  output logic [byte_offset_width_c-1:0] pkt_part_sel_o
);

  localparam int id_width_lp = safe_clog2_f(max_outstanding_p);

  logic                           issue;
  logic [byte_offset_width_c-1:0] byte_offset;
  logic [hash_input_width_c-1:0]  hash_in;
  logic [bank_width_c-1:0]        hash_bank;
  logic [hash_index_width_c-1:0]  hash_index;
  logic [mc_mask_width_c-1:0]     base_mask;
  logic [mc_mask_width_c-1:0]     store_mask;

  ////////////////////////////////////////
  // issue control
  ////////////////////////////////////////
  // one event pops the head, claims the id and sends the packet
  assign issue            = cmd.v & alloc.alloc_v & pkt_ready_i;
  assign cmd.yumi         = issue;
  assign alloc.alloc_yumi = issue;
  assign alloc.tag        = cmd.tag;
  assign alloc.write      = cmd.write;
  assign pkt_v_o          = issue;

  assign pkt_reg_id_o = {{(reg_id_width_c - id_width_lp){1'b0}}, alloc.alloc_id};

  ////////////////////////////////////////
  // address translation
  ////////////////////////////////////////
  assign byte_offset = cmd.addr[byte_offset_width_c-1:0];
  assign hash_in     = cmd.addr[word_lsb_c + vcache_offset_width_c +: hash_input_width_c];
  assign hash_bank   = bank_width_c'(hash_in % num_banks_c);
  assign hash_index  = hash_index_width_c'(hash_in / num_banks_c);

  always_comb
  begin
    if (cmd.addr[dram_bit_c])
    begin
      // block index followed by the word within the block
      pkt_addr_o = mc_addr_width_c'({hash_index, cmd.addr[word_lsb_c +: vcache_offset_width_c]});
      // top bit picks the cache row below the tiles
      pkt_y_o    = hash_bank[bank_width_c-1] ? mc_cord_width_c'(num_tiles_y_c + 1) : '0;
      pkt_x_o    = mc_cord_width_c'(hash_bank[bank_width_c-2:0]) + mc_cord_width_c'(1);
    end
    else
    begin
      pkt_addr_o = mc_addr_width_c'(cmd.addr[word_msb_c:word_lsb_c]);
      pkt_y_o    = mc_cord_width_c'(cmd.addr[y_msb_c:y_lsb_c]);
      pkt_x_o    = mc_cord_width_c'(cmd.addr[x_msb_c:x_lsb_c]);
    end
  end

  ////////////////////////////////////////
  // op, mask and load info
  ////////////////////////////////////////
  always_comb
  begin
    case (cmd.size)
      size_1:  base_mask = 4'h1;
      size_2:  base_mask = 4'h3;
      default: base_mask = 4'hf;
    endcase
  end

  assign store_mask = base_mask << byte_offset;

  always_comb
  begin
    if (cmd.write)
    begin
      pkt_op_o       = (store_mask == 4'hf) ? op_store_word : op_store_masked;
      pkt_mask_o     = store_mask;
      pkt_payload_o  = cmd.data << {byte_offset, 3'b000};
      pkt_part_sel_o = '0;
      pkt_is_byte_o  = 1'b0;
      pkt_is_hex_o   = 1'b0;
    end
    else
    begin
      pkt_op_o       = op_load;
      pkt_mask_o     = '0;
      pkt_payload_o  = '0;
      pkt_part_sel_o = byte_offset;
      pkt_is_byte_o  = (cmd.size == size_1);
      pkt_is_hex_o   = (cmd.size == size_2);
    end
  end

endmodule

`default_nettype wire

/* logic/mc_reorder_buffer.sv */
`default_nettype none

module mc_reorder_buffer
  import mc_bridge_pkg::*;
#(
  parameter int max_outstanding_p = 4
)
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       ret_v_i,
  input  logic [reg_id_width_c-1:0]  ret_reg_id_i,
  input  logic [mc_data_width_c-1:0] ret_data_i,
  input  logic                       resp_yumi_i,
  mc_alloc_if.buffer_mp              alloc,
  output logic                       resp_v_o,
  output logic                       resp_write_o,
  output logic [tag_width_c-1:0]     resp_tag_o,
  output logic [mc_data_width_c-1:0] resp_data_o
);

  localparam int id_width_lp  = safe_clog2_f(max_outstanding_p);
  localparam int cnt_width_lp = safe_clog2_f(max_outstanding_p + 1);

  // saved command headers and return data
  logic [tag_width_c-1:0]     tag_mem   [max_outstanding_p];
  logic                       write_mem [max_outstanding_p];
  logic [mc_data_width_c-1:0] data_mem  [max_outstanding_p];

  logic [max_outstanding_p-1:0] returned_r;
  logic [id_width_lp-1:0]       head_r;
  logic [id_width_lp-1:0]       tail_r;
  logic [cnt_width_lp-1:0]      count_r;
  logic [id_width_lp-1:0]       ret_id;
  logic                         alloc_fire;
  logic                         free_fire;

  function automatic logic [id_width_lp-1:0] next_id_f(input logic [id_width_lp-1:0] id);
    if (id == id_width_lp'(max_outstanding_p - 1))
      return '0;
    return id + 1'b1;
  endfunction

  ////////////////////////////////////////
  // allocation at the tail
  ////////////////////////////////////////
  assign alloc.alloc_v  = (count_r != cnt_width_lp'(max_outstanding_p));
  assign alloc.alloc_id = tail_r;
  assign alloc_fire     = alloc.alloc_yumi;

  assign ret_id    = ret_reg_id_i[id_width_lp-1:0];
  assign free_fire = resp_v_o & resp_yumi_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      head_r     <= '0;
      tail_r     <= '0;
      count_r    <= '0;
      returned_r <= '0;
    end
    else
    begin
      if (alloc_fire)
        tail_r <= next_id_f(tail_r);
      if (free_fire)
      begin
        head_r             <= next_id_f(head_r);
        returned_r[head_r] <= 1'b0;
      end
      // returns come back in any order
      if (ret_v_i)
        returned_r[ret_id] <= 1'b1;
      count_r <= count_r + cnt_width_lp'(alloc_fire) - cnt_width_lp'(free_fire);
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (alloc_fire)
    begin
      tag_mem[tail_r]   <= alloc.tag;
      write_mem[tail_r] <= alloc.write;
    end
    // a store answers with zero data
    if (ret_v_i)
      data_mem[ret_id] <= write_mem[ret_id] ? '0 : ret_data_i;
  end

  ////////////////////////////////////////
  // in-order response from the head
  ////////////////////////////////////////
  assign resp_v_o     = (count_r != '0) & returned_r[head_r];
  assign resp_tag_o   = tag_mem[head_r];
  assign resp_write_o = write_mem[head_r];
  assign resp_data_o  = data_mem[head_r];

endmodule

`default_nettype wire

/* logic/mc_bridge_top.sv */
`default_nettype none

module mc_bridge_top
  import mc_bridge_pkg::*;
#(
  parameter int max_outstanding_p = 4,
  parameter int queue_depth_p     = 4
)
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // processor commands
  input  logic                           cmd_v_i,
  output logic                           cmd_ready_o,
  input  logic                           cmd_write_i,
  input  msg_size_e                      cmd_size_i,
  input  logic [proc_addr_width_c-1:0]   cmd_addr_i,
  input  logic [mc_data_width_c-1:0]     cmd_data_i,
  input  logic [tag_width_c-1:0]         cmd_tag_i,
  // network request packets
  output logic                           pkt_v_o,
  input  logic                           pkt_ready_i,
  output mc_op_e                         pkt_op_o,
  output logic [mc_addr_width_c-1:0]     pkt_addr_o,
  output logic [mc_cord_width_c-1:0]     pkt_x_o,
  output logic [mc_cord_width_c-1:0]     pkt_y_o,
  output logic [reg_id_width_c-1:0]      pkt_reg_id_o,
  output logic [mc_data_width_c-1:0]     pkt_payload_o,
  output logic [mc_mask_width_c-1:0]     pkt_mask_o,
  output logic [byte_offset_width_c-1:0] pkt_part_sel_o,
  output logic                           pkt_is_byte_o,
  output logic                           pkt_is_hex_o,
  // network returns
  input  logic                           ret_v_i,
  input  logic [reg_id_width_c-1:0]      ret_reg_id_i,
  input  logic [mc_data_width_c-1:0]     ret_data_i,
  // processor responses
  output logic                           resp_v_o,
  input  logic                           resp_yumi_i,
  output logic [tag_width_c-1:0]         resp_tag_o,
  output logic                           resp_write_o,
  output logic [mc_data_width_c-1:0]     resp_data_o
);

  mc_cmd_if cmd_if ();
  mc_alloc_if #(.id_width_p(safe_clog2_f(max_outstanding_p))) alloc_if ();

  mc_cmd_queue #(.queue_depth_p(queue_depth_p)) i_cmd_queue
  (
    .clk_i, .rst_n_i,
    .cmd_v_i, .cmd_write_i, .cmd_size_i, .cmd_addr_i, .cmd_data_i, .cmd_tag_i,
    .cmd_ready_o,
    .head (cmd_if.queue_mp)
  );

  mc_packet_former #(.max_outstanding_p(max_outstanding_p)) i_packet_former
  (
    .pkt_ready_i,
    .cmd   (cmd_if.former_mp),
    .alloc (alloc_if.former_mp),
    .pkt_v_o, .pkt_is_byte_o, .pkt_is_hex_o, .pkt_op_o, .pkt_addr_o, .pkt_x_o, .pkt_y_o,
    .pkt_reg_id_o, .pkt_payload_o, .pkt_mask_o, .pkt_part_sel_o
  );

  mc_reorder_buffer #(.max_outstanding_p(max_outstanding_p)) i_reorder_buffer
  (
    .clk_i, .rst_n_i,
    .ret_v_i, .ret_reg_id_i, .ret_data_i, .resp_yumi_i,
    .alloc (alloc_if.buffer_mp),
    .resp_v_o, .resp_write_o, .resp_tag_o, .resp_data_o
  );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
#(
  parameter int period_p = 100
)
(
  output logic clk_o
);

  // free running, starts low
  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_p / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

/* verif/mc_bridge_assert.sv */
`default_nettype none

module mc_bridge_assert
  import mc_bridge_pkg::*;
#(
  parameter int max_outstanding_p = 4
)
(
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic                       pkt_v_o,
  input logic                       pkt_ready_i,
  input logic                       ret_v_i,
  input logic [reg_id_width_c-1:0]  ret_reg_id_i,
  input logic                       resp_v_o,
  input logic                       resp_yumi_i,
  input logic [tag_width_c-1:0]     resp_tag_o,
  input logic                       resp_write_o,
  input logic [mc_data_width_c-1:0] resp_data_o
);

  // response held until taken
  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (resp_v_o && !resp_yumi_i) |=> (resp_v_o && $stable(resp_tag_o)
      && $stable(resp_write_o) && $stable(resp_data_o)))
    else $error("response changed or dropped before resp_yumi_i");

  pkt_ready_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pkt_v_o |-> pkt_ready_i)
    else $error("pkt_v_o high while pkt_ready_i low");

  ret_id_range_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ret_v_i |-> (32'(ret_reg_id_i) < max_outstanding_p))
    else $error("return id out of range");

endmodule

bind mc_bridge_top mc_bridge_assert #(.max_outstanding_p(max_outstanding_p)) i_bridge_assert
(
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .pkt_v_o      (pkt_v_o),
  .pkt_ready_i  (pkt_ready_i),
  .ret_v_i      (ret_v_i),
  .ret_reg_id_i (ret_reg_id_i),
  .resp_v_o     (resp_v_o),
  .resp_yumi_i  (resp_yumi_i),
  .resp_tag_o   (resp_tag_o),
  .resp_write_o (resp_write_o),
  .resp_data_o  (resp_data_o)
);

`default_nettype wire

/* verif/tb_mc_bridge.sv */
`default_nettype none

module tb_mc_bridge
  import mc_bridge_pkg::*;
();

  localparam int max_outstanding_lp = 4;
  localparam int queue_depth_lp     = 4;
  localparam int max_tests_lp       = 64;
  localparam int num_cols_lp        = 16;
  localparam int cycles_per_test_lp = 200;

  // columns of the test file
  localparam int col_write_lp   = 0;
  localparam int col_size_lp    = 1;
  localparam int col_addr_lp    = 2;
  localparam int col_data_lp    = 3;
  localparam int col_tag_lp     = 4;
  localparam int col_ret_lp     = 5;
  localparam int col_op_lp      = 6;
  localparam int col_paddr_lp   = 7;
  localparam int col_x_lp       = 8;
  localparam int col_y_lp       = 9;
  localparam int col_mask_lp    = 10;
  localparam int col_payload_lp = 11;
  localparam int col_part_lp    = 12;
  localparam int col_byte_lp    = 13;
  localparam int col_hex_lp     = 14;
  localparam int col_resp_lp    = 15;

  logic                           clk_i;
  logic                           rst_n_i;
  logic                           cmd_v_i;
  logic                           cmd_ready_o;
  logic                           cmd_write_i;
  msg_size_e                      cmd_size_i;
  logic [proc_addr_width_c-1:0]   cmd_addr_i;
  logic [mc_data_width_c-1:0]     cmd_data_i;
  logic [tag_width_c-1:0]         cmd_tag_i;
  logic                           pkt_v_o;
  logic                           pkt_ready_i;
  mc_op_e                         pkt_op_o;
  logic [mc_addr_width_c-1:0]     pkt_addr_o;
  logic [mc_cord_width_c-1:0]     pkt_x_o;
  logic [mc_cord_width_c-1:0]     pkt_y_o;
  logic [reg_id_width_c-1:0]      pkt_reg_id_o;
  logic [mc_data_width_c-1:0]     pkt_payload_o;
  logic [mc_mask_width_c-1:0]     pkt_mask_o;
  logic [byte_offset_width_c-1:0] pkt_part_sel_o;
  logic                           pkt_is_byte_o;
  logic                           pkt_is_hex_o;
  logic                           ret_v_i;
  logic [reg_id_width_c-1:0]      ret_reg_id_i;
  logic [mc_data_width_c-1:0]     ret_data_i;
  logic                           resp_v_o;
  logic                           resp_yumi_i;
  logic [tag_width_c-1:0]         resp_tag_o;
  logic                           resp_write_o;
  logic [mc_data_width_c-1:0]     resp_data_o;

  logic [31:0] vec_mem [max_tests_lp][num_cols_lp];
  int          num_tests   = 0;
  int          cmd_count   = 0;
  int          pkt_count   = 0;
  int          resp_count  = 0;
  int          cycle_count = 0;

  // network model keeps the packets taken and not yet answered
  logic [reg_id_width_c-1:0] out_id [$];
  int                        out_test [$];
  int                        out_due [$];

  tb_clock_gen #(.period_p(100)) i_clock_gen (.clk_o(clk_i));

  mc_bridge_top #(.max_outstanding_p(max_outstanding_lp), .queue_depth_p(queue_depth_lp)) i_dut
  (
    .clk_i, .rst_n_i,
    .cmd_v_i, .cmd_ready_o, .cmd_write_i, .cmd_size_i, .cmd_addr_i, .cmd_data_i, .cmd_tag_i,
    .pkt_v_o, .pkt_ready_i, .pkt_op_o, .pkt_addr_o, .pkt_x_o, .pkt_y_o, .pkt_reg_id_o,
    .pkt_payload_o, .pkt_mask_o, .pkt_part_sel_o, .pkt_is_byte_o, .pkt_is_hex_o,
    .ret_v_i, .ret_reg_id_i, .ret_data_i,
    .resp_v_o, .resp_yumi_i, .resp_tag_o, .resp_write_o, .resp_data_o
  );

  ////////////////////////////////////////
  // reporting
  ////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      report_failure($sformatf("error %s got %h expected %h", name, actual, expected));
  endtask

  task automatic load_tests();
    int          fd;
    int          n;
    string       line;
    logic [31:0] field [num_cols_lp];
    fd = $fopen("verif/mc_bridge_testdata.txt", "r");
    if (fd == 0)
      report_failure("cannot open the test data file");
    while ($fgets(line, fd) != 0)
    begin
      // comment and blank lines
      if (line.len() < 2 || line[0] == "#")
        continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  field[0], field[1], field[2], field[3], field[4], field[5],
                  field[6], field[7], field[8], field[9], field[10], field[11],
                  field[12], field[13], field[14], field[15]);
      if (n != num_cols_lp || num_tests >= max_tests_lp)
        report_failure("malformed or too many lines in the test data file");
      for (int c = 0; c < num_cols_lp; c++)
        vec_mem[num_tests][c] = field[c];
      num_tests++;
    end
    $fclose(fd);
    if (num_tests == 0)
      report_failure("the test data file holds no tests");
  endtask

  ////////////////////////////////////////
  // checks on taken packets and responses
  ////////////////////////////////////////
  task automatic check_packet();
    int idx;
    idx = pkt_count;
    if (idx >= num_tests)
      report_failure("a packet was issued with no command left to match it");
    check_value("pkt_op_o", 32'(pkt_op_o), vec_mem[idx][col_op_lp]);
    check_value("pkt_addr_o", 32'(pkt_addr_o), vec_mem[idx][col_paddr_lp]);
    check_value("pkt_x_o", 32'(pkt_x_o), vec_mem[idx][col_x_lp]);
    check_value("pkt_y_o", 32'(pkt_y_o), vec_mem[idx][col_y_lp]);
    check_value("pkt_mask_o", 32'(pkt_mask_o), vec_mem[idx][col_mask_lp]);
    check_value("pkt_payload_o", pkt_payload_o, vec_mem[idx][col_payload_lp]);
    check_value("pkt_part_sel_o", 32'(pkt_part_sel_o), vec_mem[idx][col_part_lp]);
    check_value("pkt_is_byte_o", 32'(pkt_is_byte_o), vec_mem[idx][col_byte_lp]);
    check_value("pkt_is_hex_o", 32'(pkt_is_hex_o), vec_mem[idx][col_hex_lp]);
    // ids are handed out round the ring in issue order
    check_value("pkt_reg_id_o", 32'(pkt_reg_id_o), 32'(idx % max_outstanding_lp));
    foreach (out_id[i])
      if (out_id[i] == pkt_reg_id_o)
        report_failure($sformatf("reg_id %0d reused while still outstanding", pkt_reg_id_o));
    out_id.push_back(pkt_reg_id_o);
    out_test.push_back(idx);
    out_due.push_back(cycle_count + int'($urandom_range(1, 12)));
    pkt_count++;
  endtask

  task automatic check_response();
    int idx;
    idx = resp_count;
    if (idx >= num_tests)
      report_failure("a response came with no command left to match it");
    check_value("resp_tag_o", 32'(resp_tag_o), vec_mem[idx][col_tag_lp]);
    check_value("resp_write_o", 32'(resp_write_o), vec_mem[idx][col_write_lp]);
    check_value("resp_data_o", resp_data_o, vec_mem[idx][col_resp_lp]);
    resp_count++;
  endtask

  // handshakes as seen at the rising edge
  task automatic record_transfers();
    if (cmd_v_i && cmd_ready_o)
      cmd_count++;
    if (pkt_v_o)
      check_packet();
    if (resp_v_o && resp_yumi_i)
      check_response();
  endtask

  task automatic drive_inputs();
    int pick;
    if (cmd_count < num_tests)
    begin
      cmd_v_i     = 1'b1;
      cmd_write_i = vec_mem[cmd_count][col_write_lp][0];
      cmd_size_i  = msg_size_e'(vec_mem[cmd_count][col_size_lp][1:0]);
      cmd_addr_i  = vec_mem[cmd_count][col_addr_lp];
      cmd_data_i  = vec_mem[cmd_count][col_data_lp];
      cmd_tag_i   = vec_mem[cmd_count][col_tag_lp][tag_width_c-1:0];
    end
    else
    begin
      cmd_v_i = 1'b0;
    end
    // at most one return a cycle to any due packet
    ret_v_i = 1'b0;
    if (out_id.size() > 0)
    begin
      pick = int'($urandom_range(0, out_id.size() - 1));
      if (out_due[pick] <= cycle_count)
      begin
        ret_v_i      = 1'b1;
        ret_reg_id_i = out_id[pick];
        ret_data_i   = vec_mem[out_test[pick]][col_ret_lp];
        out_id.delete(pick);
        out_test.delete(pick);
        out_due.delete(pick);
      end
    end
    pkt_ready_i = ($urandom_range(0, 4) != 0);
    resp_yumi_i = resp_v_o && ($urandom_range(0, 3) != 0);
  endtask

  ////////////////////////////////////////
  // watchdog and main sequence
  ////////////////////////////////////////
  initial
  begin : watchdog
    // test count is final once reset is released
    @(posedge rst_n_i);
    repeat (num_tests * cycles_per_test_lp) @(posedge clk_i);
    report_failure($sformatf("timeout with %0d of %0d responses received",
                             resp_count, num_tests));
  end

  initial
  begin : stimulus
    void'($urandom(14531));
    rst_n_i      = 1'b0;
    cmd_v_i      = 1'b0;
    cmd_write_i  = 1'b0;
    cmd_size_i   = size_1;
    cmd_addr_i   = '0;
    cmd_data_i   = '0;
    cmd_tag_i    = '0;
    pkt_ready_i  = 1'b0;
    ret_v_i      = 1'b0;
    ret_reg_id_i = '0;
    ret_data_i   = '0;
    resp_yumi_i  = 1'b0;
    load_tests();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    // idle state out of reset
    check_value("cmd_ready_o", 32'(cmd_ready_o), 32'd1);
    check_value("pkt_v_o", 32'(pkt_v_o), 32'd0);
    check_value("resp_v_o", 32'(resp_v_o), 32'd0);
    rst_n_i = 1'b1;
    drive_inputs();
    while (resp_count < num_tests)
    begin
      @(posedge clk_i);
      cycle_count++;
      record_transfers();
      @(negedge clk_i);
      drive_inputs();
    end
    check_value("cmd_count", 32'(cmd_count), 32'(num_tests));
    check_value("pkt_count", 32'(pkt_count), 32'(num_tests));
    check_value("outstanding", 32'(out_id.size()), 32'd0);
    // nothing extra may follow the last response
    repeat (5)
    begin
      @(posedge clk_i);
      check_value("pkt_v_o", 32'(pkt_v_o), 32'd0);
      check_value("resp_v_o", 32'(resp_v_o), 32'd0);
      @(negedge clk_i);
      drive_inputs();
    end
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
logic/mc_bridge_pkg.sv
logic/mc_bridge_if.sv
logic/mc_cmd_queue.sv
logic/mc_packet_former.sv
logic/mc_reorder_buffer.sv
logic/mc_bridge_top.sv
verif/tb_clock_gen.sv
verif/mc_bridge_assert.sv
verif/tb_mc_bridge.sv

/* Makefile */
SIM       := verilator
TOP       := tb_mc_bridge
FILELIST  := files.f
SIM_FLAGS := --binary --assert -j 0
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TB FAILED" $(LOG); then \
	  echo "simulation failed"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/mc_bridge_testdata.txt */
# write size addr data tag ret | expected op addr x y mask payload part_sel is_byte is_hex resp
# all hex; size 0/1/2 = 1/2/4 bytes; op 0 load, 1 store word, 2 store masked
0 2 0108048c 00000000 01 11223344 0 00000123 02 01 0 00000000 0 0 0 11223344
0 0 0316af37 00000000 02 a5a5a5a5 0 0000abcd 05 03 0 00000000 3 1 0 a5a5a5a5
0 1 3ffffffe 00000000 03 0badcafe 0 0000ffff 3f 3f 0 00000000 2 0 1 0badcafe
1 2 02040040 deadbeef 04 12345678 1 00000010 01 02 f deadbeef 0 0 0 00000000
1 0 01040080 000000aa 05 00000000 2 00000020 01 01 1 000000aa 0 0 0 00000000
1 0 01040081 000000bb 06 ffffffff 2 00000020 01 01 2 0000bb00 0 0 0 00000000
1 0 01040082 000000cc 07 00000000 2 00000020 01 01 4 00cc0000 0 0 0 00000000
1 0 01040083 000000dd 08 00000000 2 00000020 01 01 8 dd000000 0 0 0 00000000
1 1 01040080 00001234 09 00000000 2 00000020 01 01 3 00001234 0 0 0 00000000
1 1 01040082 00005678 0a 00000000 2 00000020 01 01 c 56780000 0 0 0 00000000
1 1 01040081 00009abc 0b 00000000 2 00000020 01 01 6 009abc00 0 0 0 00000000
1 2 01040081 11223344 0c 00000000 2 00000020 01 01 e 22334400 0 0 0 00000000
0 2 80001234 00000000 0d 0000cafe 0 00000095 02 00 0 00000000 0 0 0 0000cafe
0 2 800000e8 00000000 0e 76543210 0 00000002 04 09 0 00000000 0 0 0 76543210
1 2 c0abcd9c 0f0f0f0f 0f 00000001 1 02055e6f 01 09 f 0f0f0f0f 0 0 0 00000000
1 0 8000007b 00000077 10 00000000 2 00000006 04 00 8 77000000 0 0 0 00000000
0 1 80ffff42 00000000 11 feedface 0 0007fff8 03 00 0 00000000 2 0 1 feedface
0 0 800001b1 00000000 12 000000ab 0 0000000c 02 09 0 00000000 1 1 0 000000ab
0 2 041c0004 00000000 13 89abcdef 0 00000001 07 04 0 00000000 0 0 0 89abcdef
0 0 00000001 00000000 14 000000ff 0 00000000 00 00 0 00000000 1 1 0 000000ff
1 2 0524c000 55aa55aa 15 9999aaaa 1 00003000 09 05 f 55aa55aa 0 0 0 00000000
0 2 fffffffc 00000000 16 13579bdf 0 03ffffff 04 09 0 00000000 0 0 0 13579bdf
